// ==== mem_ctrl.sv ====
`include "mem_macros.svh"

module mem_ctrl (
	input  logic                clk,
	input  logic                rst_i,
	input  logic                stall_i,
	input  logic                mdu_stallreq_i,
	input  logic                flush_i,
	input  logic                ex_valid_i,
	input  logic [`MEMOP_W-1:0] ex_memop_i,
	input  logic [`DATA_W-1:0]  ex_addr_i,
	input  logic [`REG_AW-1:0]  ex_waddr_i,
	input  logic [`DATA_W-1:0]  ex_wdata_i,
	input  logic [`WREN_W-1:0]  ex_wren_i,
	input  logic [`DATA_W-1:0]  ex_pc_i,
	output logic                stall_o,
	output logic                stage_en_o,
	output logic                ram_en_o,
	output logic                ram_we_o,
	output logic [`MEMOP_W-1:0] m_memop_o,
	output logic [1:0]          m_addr_low_o,
	output logic [`REG_AW-1:0]  m_waddr_o,
	output logic [`DATA_W-1:0]  m_wdata_o,
	output logic [`WREN_W-1:0]  m_wren_o,
	output logic [`DATA_W-1:0]  m_pc_o,
	output logic                m_exc_o,
	output logic                m_load_o
);

	logic hold;
	logic is_load;
	logic is_store;
	logic half_op;
	logic word_op;
	logic addr_err;
	logic access;

	assign hold       = stall_i | mdu_stallreq_i;
	assign stage_en_o = ~hold;
	assign stall_o    = hold;

	assign is_load  = ex_memop_i[`OP_LB]  | ex_memop_i[`OP_LBU] | ex_memop_i[`OP_LH]
	                | ex_memop_i[`OP_LHU] | ex_memop_i[`OP_LW]  | ex_memop_i[`OP_LWL]
	                | ex_memop_i[`OP_LWR];
	assign is_store = ex_memop_i[`OP_SB]  | ex_memop_i[`OP_SH]  | ex_memop_i[`OP_SW]
	                | ex_memop_i[`OP_SWL] | ex_memop_i[`OP_SWR];

	// unaligned lwl/lwr/swl/swr are legal, so only plain half and word accesses count
	assign half_op  = ex_memop_i[`OP_LH] | ex_memop_i[`OP_LHU] | ex_memop_i[`OP_SH];
	assign word_op  = ex_memop_i[`OP_LW] | ex_memop_i[`OP_SW];
	assign addr_err = ex_valid_i & ((half_op & ex_addr_i[0]) | (word_op & (|ex_addr_i[1:0])));

	// a flushed or faulting access never touches the RAM
	assign access   = ex_valid_i & (is_load | is_store) & ~addr_err & ~flush_i & ~hold;
	assign ram_en_o = access;
	assign ram_we_o = access & is_store;

	always_ff @(posedge clk) begin
		if (rst_i) begin
			m_memop_o <= '0;
			m_waddr_o <= '0;
			m_wdata_o <= '0;
			m_wren_o  <= '0;
			m_exc_o   <= 1'b0;
			m_load_o  <= 1'b0;
		end else if (!hold) begin
			if (flush_i || !ex_valid_i) begin
				// bubble
				m_memop_o <= '0;
				m_waddr_o <= '0;
				m_wdata_o <= '0;
				m_wren_o  <= '0;
				m_exc_o   <= 1'b0;
				m_load_o  <= 1'b0;
			end else begin
				m_memop_o <= addr_err ? '0 : ex_memop_i;
				m_waddr_o <= ex_waddr_i;
				m_wdata_o <= ex_wdata_i;
				// stores and faulting ops write no register
				m_wren_o  <= (addr_err || is_store) ? '0 : ex_wren_i;
				m_exc_o   <= addr_err;
				m_load_o  <= is_load & ~addr_err;
			end
		end
	end

	// pc survives a flush so a later fault report still has it
	always_ff @(posedge clk) begin
		if (!hold) begin
			m_pc_o       <= ex_pc_i;
			m_addr_low_o <= ex_addr_i[1:0];
		end
	end

	a_memop_onehot: assert property (@(posedge clk) disable iff (rst_i)
		ex_valid_i |-> $onehot0(ex_memop_i))
		else $error("ex_memop_i not one-hot: %h", ex_memop_i);

endmodule

// ==== mem_data_ram.sv ====
`include "mem_macros.svh"

module mem_data_ram
	import mem_pkg::*;
(
	input  logic               clk,
	input  logic               en_i,
	input  logic               we_i,
	input  logic [3:0]         be_i,
	input  logic [`RAM_AW-1:0] addr_i,
	input  logic [`DATA_W-1:0] wdata_i,
	output mem_word_u          rdata_o
);

	localparam int DEPTH = 1 << `RAM_AW;

	logic [3:0][7:0] mem [DEPTH];
	logic [3:0][7:0] wlanes;

	assign wlanes = wdata_i;

	initial begin
		for (int i = 0; i < DEPTH; i++) begin
			mem[i] = '0;
		end
	end

	// rdata only moves on an enabled access, so it holds through a stall
	always_ff @(posedge clk) begin
		if (en_i) begin
			if (we_i) begin
				for (int b = 0; b < 4; b++) begin
					if (be_i[b]) begin
						mem[addr_i][b] <= wlanes[b];
					end
				end
			end
			rdata_o.word <= mem[addr_i];
		end
	end

	a_be_on_write: assert property (@(posedge clk) we_i |-> (be_i != 4'b0000))
		else $error("RAM write with empty byte enable at %h", addr_i);

endmodule

// ==== mem_load_stage.sv ====
`include "mem_macros.svh"

module mem_load_stage
	import mem_pkg::*;
(
	input  logic                clk,
	input  logic                rst_i,
	input  logic                en_i,
	input  logic                flush_i,
	input  logic [`MEMOP_W-1:0] memop_i,
	input  logic [1:0]          addr_low_i,
	input  mem_word_u           rdata_i,
	input  logic [`REG_AW-1:0]  waddr_i,
	input  logic [`DATA_W-1:0]  wdata_i,
	input  logic [`WREN_W-1:0]  wren_i,
	input  logic [`DATA_W-1:0]  pc_i,
	input  logic                exc_i,
	input  logic                load_i,
	output logic [`REG_AW-1:0]  wb_waddr_o,
	output logic [`DATA_W-1:0]  wb_wdata_o,
	output logic [`WREN_W-1:0]  wb_wren_o,
	output logic [`DATA_W-1:0]  wb_pc_o,
	output logic                wb_exc_o,
	output logic [`REG_AW-1:0]  byp_waddr_o,
	output logic [`DATA_W-1:0]  byp_wdata_o,
	output logic                byp_nofwd_o
);

	logic [7:0]          sel_byte;
	logic [15:0]         sel_half;
	logic [`DATA_W-1:0]  lwl_res;
	logic [`DATA_W-1:0]  lwr_res;
	logic [`WREN_W-1:0]  lwl_mask;
	logic [`WREN_W-1:0]  lwr_mask;
	logic [`DATA_W-1:0]  load_res;
	logic [`WREN_W-1:0]  wren_next;

	// lane picks straight from the union views
	assign sel_byte = rdata_i.lane[addr_low_i];
	assign sel_half = rdata_i.half[addr_low_i[1]];

	// lwl fills the register from the top, the mask tells writeback which bytes
	always_comb begin
		case (addr_low_i)
			2'd0: begin
				lwl_res  = {rdata_i.lane[0], 24'b0};
				lwl_mask = 4'b1000;
			end
			2'd1: begin
				lwl_res  = {rdata_i.half[0], 16'b0};
				lwl_mask = 4'b1100;
			end
			2'd2: begin
				lwl_res  = {rdata_i.word[23:0], 8'b0};
				lwl_mask = 4'b1110;
			end
			default: begin
				lwl_res  = rdata_i.word;
				lwl_mask = 4'b1111;
			end
		endcase
	end

	// lwr fills from the bottom
	always_comb begin
		case (addr_low_i)
			2'd0: begin
				lwr_res  = rdata_i.word;
				lwr_mask = 4'b1111;
			end
			2'd1: begin
				lwr_res  = {8'b0, rdata_i.word[31:8]};
				lwr_mask = 4'b0111;
			end
			2'd2: begin
				lwr_res  = {16'b0, rdata_i.half[1]};
				lwr_mask = 4'b0011;
			end
			default: begin
				lwr_res  = {24'b0, rdata_i.lane[3]};
				lwr_mask = 4'b0001;
			end
		endcase
	end

	always_comb begin
		load_res = rdata_i.word;
		if (memop_i[`OP_LB])       load_res = {{24{sel_byte[7]}}, sel_byte};
		else if (memop_i[`OP_LBU]) load_res = {24'b0, sel_byte};
		else if (memop_i[`OP_LH])  load_res = {{16{sel_half[15]}}, sel_half};
		else if (memop_i[`OP_LHU]) load_res = {16'b0, sel_half};
		else if (memop_i[`OP_LWL]) load_res = lwl_res;
		else if (memop_i[`OP_LWR]) load_res = lwr_res;
	end

	assign wren_next = (load_i && memop_i[`OP_LWL]) ? lwl_mask :
	                   (load_i && memop_i[`OP_LWR]) ? lwr_mask :
	                   wren_i;

	// hazard logic must not forward a load result, it only exists after this stage
	assign byp_waddr_o = waddr_i;
	assign byp_wdata_o = wdata_i;
	assign byp_nofwd_o = load_i;

	always_ff @(posedge clk) begin
		if (rst_i) begin
			wb_waddr_o <= '0;
			wb_wdata_o <= '0;
			wb_wren_o  <= '0;
			wb_exc_o   <= 1'b0;
		end else if (en_i) begin
			if (flush_i) begin
				wb_waddr_o <= '0;
				wb_wdata_o <= '0;
				wb_wren_o  <= '0;
				wb_exc_o   <= 1'b0;
			end else begin
				wb_waddr_o <= waddr_i;
				wb_wdata_o <= load_i ? load_res : wdata_i;
				wb_wren_o  <= wren_next;
				wb_exc_o   <= exc_i;
			end
		end
	end

	always_ff @(posedge clk) begin
		if (en_i) begin
			wb_pc_o <= pc_i;
		end
	end

	a_exc_no_write: assert property (@(posedge clk) disable iff (rst_i)
		wb_exc_o |-> (wb_wren_o == '0))
		else $error("address error entry writes register %h", wb_waddr_o);

endmodule

// ==== mem_macros.svh ====
`ifndef MEM_MACROS_SVH
`define MEM_MACROS_SVH

// datapath widths
`define DATA_W 32
`define REG_AW 5
`define WREN_W 4

// one-hot memory operation vector, one bit per access kind
`define MEMOP_W 12
`define OP_LB   0
`define OP_LBU  1
`define OP_LH   2
`define OP_LHU  3
`define OP_LW   4
`define OP_SB   5
`define OP_SH   6
`define OP_SW   7
`define OP_LWL  8
`define OP_LWR  9
`define OP_SWL  10
`define OP_SWR  11

// data RAM word address width, 256 words by default
`define RAM_AW 8

`endif

// ==== mem_pkg.sv ====
`include "mem_macros.svh"

package mem_pkg;

	// one RAM word, seen as byte lanes, halfword lanes or the whole word
	// lane 0 and half 0 are the least significant
	typedef union packed {
		logic [3:0][7:0]      lane;
		logic [1:0][15:0]     half;
		logic [`DATA_W-1:0]   word;
	} mem_word_u;

endpackage

// ==== mem_store_align.sv ====
`include "mem_macros.svh"

module mem_store_align (
	input  logic [`MEMOP_W-1:0] memop_i,
	input  logic [1:0]          addr_low_i,
	input  logic [`DATA_W-1:0]  store_data_i,
	output logic [3:0]          ram_be_o,
	output logic [`DATA_W-1:0]  ram_wdata_o
);

	// 3 - a in two bits is just the complement of a
	logic [1:0] inv_low;
	logic [4:0] shamt_l;
	logic [4:0] shamt_r;

	assign inv_low = ~addr_low_i;
	assign shamt_l = {inv_low, 3'b000};
	assign shamt_r = {addr_low_i, 3'b000};

	always_comb begin
		ram_be_o    = 4'b0000;
		ram_wdata_o = store_data_i;
		if (memop_i[`OP_SB]) begin
			// replicate the byte, the enable picks the lane
			ram_be_o    = 4'b0001 << addr_low_i;
			ram_wdata_o = {4{store_data_i[7:0]}};
		end else if (memop_i[`OP_SH]) begin
			ram_be_o    = 4'b0011 << addr_low_i;
			ram_wdata_o = {2{store_data_i[15:0]}};
		end else if (memop_i[`OP_SW]) begin
			ram_be_o    = 4'b1111;
			ram_wdata_o = store_data_i;
		end else if (memop_i[`OP_SWL]) begin
			// upper bytes of rt go to the low end of the word, up to the address
			ram_be_o    = 4'b1111 >> inv_low;
			ram_wdata_o = store_data_i >> shamt_l;
		end else if (memop_i[`OP_SWR]) begin
			// lower bytes of rt go from the address up to the top lane
			ram_be_o    = 4'b1111 << addr_low_i;
			ram_wdata_o = store_data_i << shamt_r;
		end
	end

endmodule

// ==== mem_top.sv ====
`include "mem_macros.svh"

module mem_top
	import mem_pkg::*;
(
	input  logic                clk,
	input  logic                rst_i,
	input  logic                stall_i,
	input  logic                mdu_stallreq_i,
	input  logic                flush_i,
	input  logic                ex_valid_i,
	input  logic [`MEMOP_W-1:0] ex_memop_i,
	input  logic [`DATA_W-1:0]  ex_addr_i,
	input  logic [`DATA_W-1:0]  ex_store_data_i,
	input  logic [`REG_AW-1:0]  ex_waddr_i,
	input  logic [`DATA_W-1:0]  ex_wdata_i,
	input  logic [`WREN_W-1:0]  ex_wren_i,
	input  logic [`DATA_W-1:0]  ex_pc_i,
	output logic                stall_o,
	output logic [`REG_AW-1:0]  wb_waddr_o,
	output logic [`DATA_W-1:0]  wb_wdata_o,
	output logic [`WREN_W-1:0]  wb_wren_o,
	output logic [`DATA_W-1:0]  wb_pc_o,
	output logic                wb_exc_o,
	output logic [`REG_AW-1:0]  byp_waddr_o,
	output logic [`DATA_W-1:0]  byp_wdata_o,
	output logic                byp_nofwd_o
);

	logic                stage_en;
	logic                ram_en;
	logic                ram_we;
	logic [3:0]          ram_be;
	logic [`DATA_W-1:0]  ram_wdata;
	mem_word_u           ram_rdata;
	logic [`MEMOP_W-1:0] m_memop;
	logic [1:0]          m_addr_low;
	logic [`REG_AW-1:0]  m_waddr;
	logic [`DATA_W-1:0]  m_wdata;
	logic [`WREN_W-1:0]  m_wren;
	logic [`DATA_W-1:0]  m_pc;
	logic                m_exc;
	logic                m_load;

	mem_ctrl u_ctrl (
		.clk            (clk),
		.rst_i          (rst_i),
		.stall_i        (stall_i),
		.mdu_stallreq_i (mdu_stallreq_i),
		.flush_i        (flush_i),
		.ex_valid_i     (ex_valid_i),
		.ex_memop_i     (ex_memop_i),
		.ex_addr_i      (ex_addr_i),
		.ex_waddr_i     (ex_waddr_i),
		.ex_wdata_i     (ex_wdata_i),
		.ex_wren_i      (ex_wren_i),
		.ex_pc_i        (ex_pc_i),
		.stall_o        (stall_o),
		.stage_en_o     (stage_en),
		.ram_en_o       (ram_en),
		.ram_we_o       (ram_we),
		.m_memop_o      (m_memop),
		.m_addr_low_o   (m_addr_low),
		.m_waddr_o      (m_waddr),
		.m_wdata_o      (m_wdata),
		.m_wren_o       (m_wren),
		.m_pc_o         (m_pc),
		.m_exc_o        (m_exc),
		.m_load_o       (m_load)
	);

	mem_store_align u_store_align (
		.memop_i      (ex_memop_i),
		.addr_low_i   (ex_addr_i[1:0]),
		.store_data_i (ex_store_data_i),
		.ram_be_o     (ram_be),
		.ram_wdata_o  (ram_wdata)
	);

	// word address drops the byte offset
	mem_data_ram u_ram (
		.clk     (clk),
		.en_i    (ram_en),
		.we_i    (ram_we),
		.be_i    (ram_be),
		.addr_i  (ex_addr_i[`RAM_AW+1:2]),
		.wdata_i (ram_wdata),
		.rdata_o (ram_rdata)
	);

	mem_load_stage u_load_stage (
		.clk         (clk),
		.rst_i       (rst_i),
		.en_i        (stage_en),
		.flush_i     (flush_i),
		.memop_i     (m_memop),
		.addr_low_i  (m_addr_low),
		.rdata_i     (ram_rdata),
		.waddr_i     (m_waddr),
		.wdata_i     (m_wdata),
		.wren_i      (m_wren),
		.pc_i        (m_pc),
		.exc_i       (m_exc),
		.load_i      (m_load),
		.wb_waddr_o  (wb_waddr_o),
		.wb_wdata_o  (wb_wdata_o),
		.wb_wren_o   (wb_wren_o),
		.wb_pc_o     (wb_pc_o),
		.wb_exc_o    (wb_exc_o),
		.byp_waddr_o (byp_waddr_o),
		.byp_wdata_o (byp_wdata_o),
		.byp_nofwd_o (byp_nofwd_o)
	);

endmodule

// ==== run_sim.sh ====
#!/bin/sh
# builds and runs the memory-stage testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert --timescale 1ns/1ps \
	-f sim.f --top-module tb_mem_top -Mdir obj_dir > build.log 2>&1
if [ $? -ne 0 ]; then
	echo "compile failed, see build.log"
	exit 1
fi

./obj_dir/Vtb_mem_top > sim.log 2>&1
run_status=$?
if [ $run_status -ne 0 ]; then
	echo "simulation exited with status $run_status, see sim.log"
	exit 1
fi

if grep -qx "TEST PASSED" sim.log; then
	echo "simulation passed"
	exit 0
fi
echo "simulation failed, see sim.log"
exit 1

// ==== sim.f ====
+incdir+.
mem_pkg.sv
mem_ctrl.sv
mem_store_align.sv
mem_data_ram.sv
mem_load_stage.sv
mem_top.sv
tb_mem_top.sv

// ==== tb_mem_top.sv ====
`include "mem_macros.svh"

module tb_mem_top;
	timeunit 1ns;
	timeprecision 1ps;

	localparam int CLK_NS      = 40;
	localparam int N_TRANS     = 128;
	localparam int WATCHDOG_NS = (N_TRANS * 4 + 16 + 50) * CLK_NS;
	localparam int MEM_BYTES   = 4 << `RAM_AW;
	// word aligned and inside the RAM
	localparam logic [31:0] WORD_MASK = MEM_BYTES - 4;

	logic                clk;
	logic                rst_i;
	logic                stall_i;
	logic                mdu_stallreq_i;
	logic                flush_i;
	logic                ex_valid_i;
	logic [`MEMOP_W-1:0] ex_memop_i;
	logic [`DATA_W-1:0]  ex_addr_i;
	logic [`DATA_W-1:0]  ex_store_data_i;
	logic [`REG_AW-1:0]  ex_waddr_i;
	logic [`DATA_W-1:0]  ex_wdata_i;
	logic [`WREN_W-1:0]  ex_wren_i;
	logic [`DATA_W-1:0]  ex_pc_i;
	logic                stall_o;
	logic [`REG_AW-1:0]  wb_waddr_o;
	logic [`DATA_W-1:0]  wb_wdata_o;
	logic [`WREN_W-1:0]  wb_wren_o;
	logic [`DATA_W-1:0]  wb_pc_o;
	logic                wb_exc_o;
	logic [`REG_AW-1:0]  byp_waddr_o;
	logic [`DATA_W-1:0]  byp_wdata_o;
	logic                byp_nofwd_o;

	// expected memory-stage and writeback entries
	logic [`REG_AW-1:0]  exp_m_waddr;
	logic [`DATA_W-1:0]  exp_m_wdata;
	logic [`DATA_W-1:0]  exp_m_res;
	logic [`WREN_W-1:0]  exp_m_wren;
	logic [`DATA_W-1:0]  exp_m_pc;
	logic                exp_m_exc;
	logic                exp_m_load;
	logic [`REG_AW-1:0]  exp_wb_waddr;
	logic [`DATA_W-1:0]  exp_wb_wdata;
	logic [`WREN_W-1:0]  exp_wb_wren;
	logic [`DATA_W-1:0]  exp_wb_pc;
	logic                exp_wb_exc;

	logic [7:0]  shadow [MEM_BYTES];
	logic        m_err;
	logic        m_ld;
	logic        m_st;
	logic [31:0] pc_next;
	int          seed = 19;
	int          n_trans;
	int          n_mismatch;
	int          n_other;

	mem_top DUT (.*);

	initial begin
		clk = 1'b0;
		forever #(CLK_NS / 2) clk = ~clk;
	end

	function automatic logic [31:0] next_rand();
		return $random(seed);
	endfunction

	function automatic logic [31:0] rand_addr();
		return next_rand() & WORD_MASK;
	endfunction

	function automatic logic [7:0] mem_byte(input logic [31:0] addr);
		return shadow[addr[`RAM_AW+1:0]];
	endfunction

	function automatic logic is_load(input logic [`MEMOP_W-1:0] op);
		return op[`OP_LB] | op[`OP_LBU] | op[`OP_LH] | op[`OP_LHU] | op[`OP_LW]
			| op[`OP_LWL] | op[`OP_LWR];
	endfunction

	function automatic logic is_store(input logic [`MEMOP_W-1:0] op);
		return op[`OP_SB] | op[`OP_SH] | op[`OP_SW] | op[`OP_SWL] | op[`OP_SWR];
	endfunction

	// lwl, lwr, swl and swr never fault
	function automatic logic misaligned(input logic [`MEMOP_W-1:0] op, input logic [31:0] addr);
		if (op[`OP_LH] || op[`OP_LHU] || op[`OP_SH]) begin
			return addr[0];
		end
		return (op[`OP_LW] || op[`OP_SW]) && (addr[1:0] != 2'b00);
	endfunction

	function automatic logic [31:0] load_value(input logic [`MEMOP_W-1:0] op,
			input logic [31:0] addr);
		logic [31:0] base;
		logic [7:0]  b;
		logic [15:0] h;
		logic [31:0] res;
		int          a;
		base = {addr[31:2], 2'b00};
		a    = int'(addr[1:0]);
		b    = mem_byte(addr);
		h    = {mem_byte(addr + 1), mem_byte(addr)};
		res  = {mem_byte(base + 3), mem_byte(base + 2), mem_byte(base + 1), mem_byte(base)};
		if (op[`OP_LB])
			res = {{24{b[7]}}, b};
		else if (op[`OP_LBU])
			res = {24'h0, b};
		else if (op[`OP_LH])
			res = {{16{h[15]}}, h};
		else if (op[`OP_LHU])
			res = {16'h0, h};
		else if (op[`OP_LWL] || op[`OP_LWR]) begin
			for (int j = 0; j < 4; j++) begin
				// lwl fills the top 1+a bytes, lwr the low 4-a bytes
				if (op[`OP_LWL])
					res[8*j +: 8] = (j >= 3 - a) ? mem_byte(base + j - (3 - a)) : 8'h00;
				else
					res[8*j +: 8] = (j <= 3 - a) ? mem_byte(base + j + a) : 8'h00;
			end
		end
		return res;
	endfunction

	function automatic logic [3:0] load_mask(input logic [`MEMOP_W-1:0] op,
			input logic [31:0] addr, input logic [3:0] wren);
		logic [3:0] m;
		int         a;
		a = int'(addr[1:0]);
		m = wren;
		for (int j = 0; j < 4; j++) begin
			if (op[`OP_LWL])
				m[j] = (j >= 3 - a);
			else if (op[`OP_LWR])
				m[j] = (j <= 3 - a);
		end
		return m;
	endfunction

	task automatic apply_store(input logic [`MEMOP_W-1:0] op, input logic [31:0] addr,
			input logic [31:0] rt);
		logic [31:0] byte_addr;
		logic        hit;
		logic [7:0]  val;
		int          a;
		a = int'(addr[1:0]);
		for (int j = 0; j < 4; j++) begin
			hit = 1'b1;
			val = 8'h00;
			if (op[`OP_SB] && j == a)
				val = rt[7:0];
			else if (op[`OP_SH] && (j == a || j == a + 1))
				val = rt[8*(j-a) +: 8];
			else if (op[`OP_SW])
				val = rt[8*j +: 8];
			else if (op[`OP_SWL] && j <= a)
				val = rt[8*(3-a+j) +: 8];
			else if (op[`OP_SWR] && j >= a)
				val = rt[8*(j-a) +: 8];
			else
				hit = 1'b0;
			byte_addr = {addr[31:2], 2'b00} + j;
			if (hit)
				shadow[byte_addr[`RAM_AW+1:0]] = val;
		end
	endtask

	task automatic report_mismatch(input string name, input logic [31:0] expv,
			input logic [31:0] actv);
		n_mismatch++;
		$display("FAILED %s expected %h actual %h", name, expv, actv);
	endtask

	// two-entry reference pipeline
	always @(posedge clk) begin
		if (rst_i) begin
			exp_m_waddr  <= '0;
			exp_m_wdata  <= '0;
			exp_m_res    <= '0;
			exp_m_wren   <= '0;
			exp_m_exc    <= 1'b0;
			exp_m_load   <= 1'b0;
			exp_wb_waddr <= '0;
			exp_wb_wdata <= '0;
			exp_wb_wren  <= '0;
			exp_wb_exc   <= 1'b0;
		end else if (!(stall_i || mdu_stallreq_i)) begin
			exp_wb_waddr <= flush_i ? '0 : exp_m_waddr;
			exp_wb_wdata <= flush_i ? '0 : exp_m_res;
			exp_wb_wren  <= flush_i ? '0 : exp_m_wren;
			exp_wb_exc   <= flush_i ? 1'b0 : exp_m_exc;
			if (flush_i || !ex_valid_i) begin
				exp_m_waddr <= '0;
				exp_m_wdata <= '0;
				exp_m_res   <= '0;
				exp_m_wren  <= '0;
				exp_m_exc   <= 1'b0;
				exp_m_load  <= 1'b0;
			end else begin
				m_err = misaligned(ex_memop_i, ex_addr_i);
				m_ld  = is_load(ex_memop_i) && !m_err;
				m_st  = is_store(ex_memop_i);
				exp_m_waddr <= ex_waddr_i;
				exp_m_wdata <= ex_wdata_i;
				exp_m_exc   <= m_err;
				exp_m_load  <= m_ld;
				exp_m_res   <= m_ld ? load_value(ex_memop_i, ex_addr_i) : ex_wdata_i;
				if (m_err || m_st)
					exp_m_wren <= 4'b0000;
				else
					exp_m_wren <= load_mask(ex_memop_i, ex_addr_i, ex_wren_i);
				if (m_st && !m_err)
					apply_store(ex_memop_i, ex_addr_i, ex_store_data_i);
			end
		end
	end

	// pc moves on every enabled edge even under flush
	always @(posedge clk) begin
		if (!(stall_i || mdu_stallreq_i)) begin
			exp_m_pc  <= ex_pc_i;
			exp_wb_pc <= exp_m_pc;
		end
	end

	wdata_chk: assert property (@(negedge clk) disable iff (rst_i) wb_wdata_o == exp_wb_wdata)
		else report_mismatch("wb_wdata_o", exp_wb_wdata, wb_wdata_o);
	wren_chk: assert property (@(negedge clk) disable iff (rst_i) wb_wren_o == exp_wb_wren)
		else report_mismatch("wb_wren_o", 32'(exp_wb_wren), 32'(wb_wren_o));
	waddr_chk: assert property (@(negedge clk) disable iff (rst_i) wb_waddr_o == exp_wb_waddr)
		else report_mismatch("wb_waddr_o", 32'(exp_wb_waddr), 32'(wb_waddr_o));
	exc_chk: assert property (@(negedge clk) disable iff (rst_i) wb_exc_o == exp_wb_exc)
		else report_mismatch("wb_exc_o", 32'(exp_wb_exc), 32'(wb_exc_o));
	pc_chk: assert property (@(negedge clk) disable iff (rst_i)
		wb_exc_o |-> wb_pc_o == exp_wb_pc)
		else report_mismatch("wb_pc_o", exp_wb_pc, wb_pc_o);
	nofwd_chk: assert property (@(negedge clk) disable iff (rst_i) byp_nofwd_o == exp_m_load)
		else report_mismatch("byp_nofwd_o", 32'(exp_m_load), 32'(byp_nofwd_o));
	byp_waddr_chk: assert property (@(negedge clk) disable iff (rst_i)
		byp_waddr_o == exp_m_waddr)
		else report_mismatch("byp_waddr_o", 32'(exp_m_waddr), 32'(byp_waddr_o));
	byp_wdata_chk: assert property (@(negedge clk) disable iff (rst_i)
		byp_wdata_o == exp_m_wdata)
		else report_mismatch("byp_wdata_o", exp_m_wdata, byp_wdata_o);
	stall_chk: assert property (@(negedge clk) disable iff (rst_i)
		stall_o == (stall_i || mdu_stallreq_i))
		else report_mismatch("stall_o", 32'(stall_i || mdu_stallreq_i), 32'(stall_o));
	hold_chk: assert property (@(negedge clk) disable iff (rst_i)
		stall_o |=> $stable(wb_wdata_o) && $stable(wb_wren_o) && $stable(wb_exc_o))
		else begin
			n_other++;
			$display("writeback outputs changed while the stage was held");
		end

	task automatic present(input int op, input logic [31:0] addr, input logic [31:0] sdata,
			input logic fl);
		logic [`MEMOP_W-1:0] onehot;
		logic [31:0]         r;
		onehot     = '0;
		onehot[op] = 1'b1;
		r          = next_rand();
		ex_valid_i      <= 1'b1;
		ex_memop_i      <= onehot;
		ex_addr_i       <= addr;
		ex_store_data_i <= sdata;
		ex_waddr_i      <= r[`REG_AW-1:0];
		ex_wdata_i      <= next_rand();
		ex_wren_i       <= 4'hf;
		ex_pc_i         <= pc_next;
		flush_i         <= fl;
		pc_next = pc_next + 4;
		n_trans++;
	endtask

	task automatic issue(input int op, input logic [31:0] addr, input logic [31:0] sdata);
		@(posedge clk);
		present(op, addr, sdata, 1'b0);
	endtask

	task automatic issue_flushed(input int op, input logic [31:0] addr,
			input logic [31:0] sdata);
		@(posedge clk);
		present(op, addr, sdata, 1'b1);
	endtask

	// the op stays presented through the stall and enters once it ends
	task automatic issue_held(input int op, input logic [31:0] addr, input logic [31:0] sdata,
			input int span, input logic use_mdu);
		@(posedge clk);
		present(op, addr, sdata, 1'b0);
		if (use_mdu)
			mdu_stallreq_i <= 1'b1;
		else
			stall_i <= 1'b1;
		repeat (span) @(posedge clk);
		stall_i        <= 1'b0;
		mdu_stallreq_i <= 1'b0;
	endtask

	initial begin
		logic [31:0] base;
		logic [31:0] other;
		int          span;
		n_trans         = 0;
		n_mismatch      = 0;
		n_other         = 0;
		pc_next         = 32'h0000_1000;
		rst_i           = 1'b1;
		stall_i         = 1'b0;
		mdu_stallreq_i  = 1'b0;
		flush_i         = 1'b0;
		ex_valid_i      = 1'b0;
		ex_memop_i      = '0;
		ex_addr_i       = '0;
		ex_store_data_i = '0;
		ex_waddr_i      = '0;
		ex_wdata_i      = '0;
		ex_wren_i       = '0;
		ex_pc_i         = '0;
		for (int i = 0; i < MEM_BYTES; i++)
			shadow[i] = 8'h00;
		repeat (16) @(posedge clk);
		rst_i <= 1'b0;

		// sw then lw at the same word and at a random one
		repeat (8) begin
			base = rand_addr();
			issue(`OP_SW, base, next_rand());
			issue(`OP_LW, base, 32'h0);
			issue(`OP_LW, rand_addr(), 32'h0);
		end

		// byte and halfword lanes with both extensions
		repeat (2) begin
			base = rand_addr();
			for (int k = 0; k < 4; k++)
				issue(`OP_SB, base + k, next_rand());
			for (int k = 0; k < 4; k++) begin
				issue(`OP_LB, base + k, 32'h0);
				issue(`OP_LBU, base + k, 32'h0);
			end
			for (int k = 0; k < 4; k += 2)
				issue(`OP_SH, base + k, next_rand());
			for (int k = 0; k < 4; k += 2) begin
				issue(`OP_LH, base + k, 32'h0);
				issue(`OP_LHU, base + k, 32'h0);
			end
		end

		// unaligned left/right loads and stores at every offset
		base = rand_addr();
		issue(`OP_SW, base, next_rand());
		for (int k = 0; k < 4; k++) begin
			issue(`OP_LWL, base + k, 32'h0);
			issue(`OP_LWR, base + k, 32'h0);
		end
		for (int k = 0; k < 4; k++) begin
			issue(`OP_SWL, base + k, next_rand());
			issue(`OP_LW, base, 32'h0);
			issue(`OP_SWR, base + k, next_rand());
			issue(`OP_LW, base, 32'h0);
		end

		// address errors must leave memory untouched
		base = rand_addr();
		issue(`OP_SW, base, next_rand());
		issue(`OP_LW, base + 1, 32'h0);
		issue(`OP_LH, base + 1, 32'h0);
		issue(`OP_LHU, base + 3, 32'h0);
		issue(`OP_SW, base + 2, next_rand());
		issue(`OP_SH, base + 1, next_rand());
		issue(`OP_LW, base, 32'h0);

		// stall spans from both sources
		for (int k = 0; k < 8; k++) begin
			base = rand_addr();
			span = 1 + int'(next_rand() & 32'h3);
			issue(`OP_SW, base, next_rand());
			issue_held(`OP_LW, base, 32'h0, span, k[0]);
			issue(`OP_LW, rand_addr(), 32'h0);
		end

		// flush kills the entry in flight and the store presented with it
		for (int k = 0; k < 3; k++) begin
			base  = rand_addr();
			other = base ^ 32'h10;
			issue(`OP_SW, other, next_rand());
			// the middle pass has a faulting load in flight
			issue(`OP_LW, base + k[0], 32'h0);
			issue_flushed(`OP_SW, other, next_rand());
			issue(`OP_LW, other, 32'h0);
		end

		@(posedge clk);
		ex_valid_i <= 1'b0;
		flush_i    <= 1'b0;
		repeat (3) @(posedge clk);
		@(negedge clk);

		$display("errors: %0d value mismatches, %0d other failures, %0d transactions",
			n_mismatch, n_other, n_trans);
		if (n_mismatch + n_other == 0)
			$display("TEST PASSED");
		else
			$display("TEST FAILED");
		$finish;
	end

	initial begin
		#(WATCHDOG_NS);
		$display("errors: %0d value mismatches, %0d other failures, %0d transactions",
			n_mismatch, n_other, n_trans);
		$display("watchdog expired before the stimulus finished");
		$display("TEST FAILED");
		$finish;
	end

endmodule
